/* stb_macros.svh */
// strobe generator constants
// widths, schedule offsets and limits shared by every block of the design

`ifndef STB_MACROS_SVH
`define STB_MACROS_SVH

// ----------------------------------------
// timestamp
// ----------------------------------------
`define STB_T_CNT_WIDTH 32  // must stay even, counter and compare work on halves

// ----------------------------------------
// strobe shape and schedule
// ----------------------------------------
`define STB_ZERO_HOLD   1   // low cycles per strobe period
`define STB_GEN_OFFSET  7   // lead of the first target ahead of the pipeline
`define STB_PIPE_COMP   1   // state step between an event and the next add

// ----------------------------------------
// measurement
// ----------------------------------------
`define STB_MIN_PERIOD  16  // shorter periods are flagged as errors
`define STB_SYNC_STAGES 2   // sig_i synchronizer depth

`endif

/* stb_pkg.sv */
// strobe generator types
// timestamp vector and the measurement / scheduling state encoding

`include "stb_macros.svh"

package stb_pkg;

	// free-running cycle timestamp, also used for the period
	typedef logic [`STB_T_CNT_WIDTH-1:0] tstamp_t;

	// measurement, then scheduling, then a sticky error state
	typedef enum logic [3:0] {
		FIND_EDGE_1,
		FIND_EDGE_2,
		WRITE_START,
		FIND_EDGE_3,
		WRITE_END,
		COUNT_PERIOD,      // period adder in flight
		WAIT_PERIOD,
		COUNT_GEN_START,   // issue first target
		WAIT_GEN_START,
		COUNT_STROBE,      // issue end and zero-hold targets
		WAIT_STB_END,
		MEAS_ERROR
	} meas_state_e;

endpackage

/* stb_time_counter.sv */
// timestamp counter
// free-running cycle count built from two halves, the carry into the
// upper half goes through a register so the full width closes timing

`include "stb_macros.svh"

module stb_time_counter (
	input  logic             clk_i,
	input  logic             arstn_i,
	output stb_pkg::tstamp_t t_cnt_o
);
	localparam int unsigned HALF = `STB_T_CNT_WIDTH / 2;

	logic [HALF-1:0] lo_q;     // low half, counts every cycle
	logic [HALF-1:0] lo_d1_q;  // low half lined up with the high half
	logic [HALF-1:0] hi_q;
	logic [HALF-1:0] lo_inc;
	logic            lo_carry;
	logic            carry_q;

	assign {lo_carry, lo_inc} = {1'b0, lo_q} + {{HALF{1'b0}}, 1'b1};

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			lo_q    <= '0;
			lo_d1_q <= '0;
			carry_q <= 1'b0;
			hi_q    <= '0;
			t_cnt_o <= '0;
		end else begin
			lo_q    <= lo_inc;
			lo_d1_q <= lo_q;
			carry_q <= lo_carry;
			// carry lands one cycle late, matched by lo_d1_q
			hi_q    <= hi_q + {{(HALF-1){1'b0}}, carry_q};
			t_cnt_o <= {hi_q, lo_d1_q};
		end
	end

endmodule

/* pipelined_adder.sv */
// two-stage timestamp adder
// low halves first with the carry kept, high halves one cycle later;
// the valid flag travels alongside the data

`include "stb_macros.svh"

module pipelined_adder (
	input  logic             clk_i,
	input  logic             valid_i,
	input  stb_pkg::tstamp_t a_i,
	input  stb_pkg::tstamp_t b_i,
	output logic             valid_o,
	output stb_pkg::tstamp_t res_o
);
	localparam int unsigned W    = `STB_T_CNT_WIDTH;
	localparam int unsigned HALF = W / 2;

	logic [HALF-1:0] lo_sum_q;
	logic            lo_carry_q;
	logic [HALF-1:0] a_hi_q;
	logic [HALF-1:0] b_hi_q;
	logic            valid_q;
	logic [HALF-1:0] hi_sum;

	// stage 1
	always_ff @(posedge clk_i) begin
		{lo_carry_q, lo_sum_q} <= {1'b0, a_i[HALF-1:0]} + {1'b0, b_i[HALF-1:0]};
		a_hi_q  <= a_i[W-1:HALF];
		b_hi_q  <= b_i[W-1:HALF];
		valid_q <= valid_i;
	end

	assign hi_sum = a_hi_q + b_hi_q + {{(HALF-1){1'b0}}, lo_carry_q};

	// stage 2
	always_ff @(posedge clk_i) begin
		res_o   <= {hi_sum, lo_sum_q};
		valid_o <= valid_q;
	end

endmodule

/* pipelined_equal.sv */
// two-stage timestamp comparator
// each half is compared first, the two results are combined next cycle

`include "stb_macros.svh"

module pipelined_equal (
	input  logic             clk_i,
	input  stb_pkg::tstamp_t a_i,
	input  stb_pkg::tstamp_t b_i,
	output logic             eq_o
);
	localparam int unsigned W    = `STB_T_CNT_WIDTH;
	localparam int unsigned HALF = W / 2;

	logic eq_lo_q;
	logic eq_hi_q;

	always_ff @(posedge clk_i) begin
		eq_lo_q <= (a_i[HALF-1:0] == b_i[HALF-1:0]);
		eq_hi_q <= (a_i[W-1:HALF] == b_i[W-1:HALF]);
		eq_o    <= eq_lo_q & eq_hi_q;  // both halves matched last cycle
	end

endmodule

/* stb_period_meas.sv */
// period measurement
// synchronizes sig_i, timestamps its rising edges and measures one period
// (second to third edge), then steps the scheduling states from the events

`include "stb_macros.svh"

module stb_period_meas (
	input  logic                 clk_i,
	input  logic                 arstn_i,
	input  logic                 sig_i,
	input  stb_pkg::tstamp_t     t_cnt_i,
	input  logic                 gen_start_evt_i,
	input  logic                 stb_end_evt_i,
	output stb_pkg::meas_state_e state_o,
	output stb_pkg::tstamp_t     period_o,
	output logic                 period_valid_o,
	output logic                 err_o
);
	logic [`STB_SYNC_STAGES-1:0] sync_q;
	logic                        sig_prev_q;
	logic                        sig_rise;
	stb_pkg::meas_state_e        state_q;
	stb_pkg::meas_state_e        state_d;
	stb_pkg::tstamp_t            t_start_q;
	stb_pkg::tstamp_t            t_start_neg;
	stb_pkg::tstamp_t            per_sum;
	logic                        per_vld;

	// ----------------------------------------
	// input sync and edge detect
	// ----------------------------------------
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			sync_q     <= '0;
			sig_prev_q <= 1'b0;
		end else begin
			sync_q     <= {sync_q[`STB_SYNC_STAGES-2:0], sig_i};
			sig_prev_q <= sync_q[`STB_SYNC_STAGES-1];
		end
	end

	assign sig_rise = sync_q[`STB_SYNC_STAGES-1] & ~sig_prev_q;

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			stb_pkg::FIND_EDGE_1: if (sig_rise) state_d = stb_pkg::FIND_EDGE_2;  // partial period
			stb_pkg::FIND_EDGE_2: if (sig_rise) state_d = stb_pkg::WRITE_START;
			stb_pkg::WRITE_START: state_d = stb_pkg::FIND_EDGE_3;
			stb_pkg::FIND_EDGE_3: if (sig_rise) state_d = stb_pkg::WRITE_END;
			stb_pkg::WRITE_END: state_d = stb_pkg::COUNT_PERIOD;
			stb_pkg::COUNT_PERIOD: state_d = stb_pkg::WAIT_PERIOD;
			stb_pkg::WAIT_PERIOD: begin
				if (per_vld) begin
					if (per_sum < stb_pkg::tstamp_t'(`STB_MIN_PERIOD))
						state_d = stb_pkg::MEAS_ERROR;
					else
						state_d = stb_pkg::COUNT_GEN_START;
				end
			end
			stb_pkg::COUNT_GEN_START: state_d = stb_pkg::WAIT_GEN_START;
			stb_pkg::WAIT_GEN_START: if (gen_start_evt_i) state_d = stb_pkg::COUNT_STROBE;
			stb_pkg::COUNT_STROBE: state_d = stb_pkg::WAIT_STB_END;
			stb_pkg::WAIT_STB_END: if (stb_end_evt_i) state_d = stb_pkg::COUNT_STROBE;
			default: state_d = stb_pkg::MEAS_ERROR;  // sticky until reset
		endcase
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i)
			state_q <= stb_pkg::FIND_EDGE_1;
		else
			state_q <= state_d;
	end

	assign state_o = state_q;
	assign err_o   = (state_q == stb_pkg::MEAS_ERROR);

	// ----------------------------------------
	// period = end stamp - start stamp
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (state_q == stb_pkg::WRITE_START) t_start_q <= t_cnt_i;
	end

	assign t_start_neg = -t_start_q;

	// both stamps taken one cycle after their edge
	pipelined_adder u_period_add (
		.clk_i   (clk_i),
		.valid_i (state_q == stb_pkg::WRITE_END),
		.a_i     (t_cnt_i),
		.b_i     (t_start_neg),
		.valid_o (per_vld),
		.res_o   (per_sum)
	);

	always_ff @(posedge clk_i) begin
		if (per_vld) period_o <= per_sum;
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i)
			period_valid_o <= 1'b0;
		else if (per_vld)
			period_valid_o <= 1'b1;
	end

	a_period_nonzero: assert property (@(posedge clk_i) disable iff (!arstn_i)
		period_valid_o |-> (period_o != '0))
		else $error("period valid with a zero period");

endmodule

/* stb_event_sched.sv */
// event scheduler
// turns the measured period into timestamp targets through pipelined adders
// and matches them against the running timestamp to fire strobe events

`include "stb_macros.svh"

module stb_event_sched (
	input  logic                 clk_i,
	input  logic                 arstn_i,
	input  stb_pkg::tstamp_t     t_cnt_i,
	input  stb_pkg::meas_state_e state_i,
	input  stb_pkg::tstamp_t     period_i,
	output logic                 gen_start_evt_o,
	output logic                 stb_end_evt_o,
	output logic                 zero_hold_evt_o
);
	// target slots
	localparam int unsigned GEN   = 0;
	localparam int unsigned SEND  = 1;  // strobe end
	localparam int unsigned ZHOLD = 2;  // zero-hold start

	// end and zero-hold targets are issued one state step after the
	// previous end event and matched two cycles late by the comparator
	localparam int unsigned LOOP_COMP = `STB_PIPE_COMP + 2;

	stb_pkg::tstamp_t ofs [3];
	logic [2:0]       add_req;
	logic [2:0]       evt;

	assign ofs[GEN]   = period_i - stb_pkg::tstamp_t'(`STB_GEN_OFFSET);
	assign ofs[SEND]  = period_i - stb_pkg::tstamp_t'(LOOP_COMP);
	assign ofs[ZHOLD] = period_i - stb_pkg::tstamp_t'(`STB_ZERO_HOLD + LOOP_COMP);

	assign add_req[GEN]   = (state_i == stb_pkg::COUNT_GEN_START);
	assign add_req[SEND]  = (state_i == stb_pkg::COUNT_STROBE);
	assign add_req[ZHOLD] = add_req[SEND];

	// ----------------------------------------
	// one adder, target and comparator per slot
	// ----------------------------------------
	for (genvar k = 0; k < 3; k++) begin : g_tgt
		stb_pkg::tstamp_t sum;
		stb_pkg::tstamp_t tgt_q;
		logic             sum_vld;
		logic             hit;
		logic [2:0]       vld_q;  // target valid, delayed to the compare output

		pipelined_adder u_add (
			.clk_i   (clk_i),
			.valid_i (add_req[k]),
			.a_i     (t_cnt_i),
			.b_i     (ofs[k]),
			.valid_o (sum_vld),
			.res_o   (sum)
		);

		always_ff @(posedge clk_i) begin
			if (sum_vld) tgt_q <= sum;
		end

		always_ff @(posedge clk_i or negedge arstn_i) begin
			if (!arstn_i) begin
				vld_q <= '0;
			end else begin
				if (sum_vld)
					vld_q[0] <= 1'b1;
				else if (k != GEN && evt[SEND])
					vld_q[0] <= 1'b0;  // consumed, wait for re-arm
				vld_q[2:1] <= vld_q[1:0];
			end
		end

		pipelined_equal u_eq (
			.clk_i (clk_i),
			.a_i   (t_cnt_i),
			.b_i   (tgt_q),
			.eq_o  (hit)
		);

		assign evt[k] = hit & vld_q[2];
	end

	assign gen_start_evt_o = evt[GEN];
	assign stb_end_evt_o   = evt[SEND];
	assign zero_hold_evt_o = evt[ZHOLD];

	// zero-hold target sits STB_ZERO_HOLD cycles ahead of the end target
	a_evt_exclusive: assert property (@(posedge clk_i) disable iff (!arstn_i)
		!(stb_end_evt_o && zero_hold_evt_o))
		else $error("strobe end and zero-hold events fired together");

endmodule

/* stb_output.sv */
// strobe output stage
// builds the strobe from end and zero-hold events, arms one strobe window
// per request and holds the output high while idle

`include "stb_macros.svh"

module stb_output (
	input  logic clk_i,
	input  logic arstn_i,
	input  logic stb_req_i,
	input  logic stb_end_evt_i,
	input  logic zero_hold_evt_i,
	output logic stb_o,
	output logic rdy_o,
	output logic stb_valid_o
);
	logic req_q;
	logic req_rise;
	logic int_stb_q;  // generated strobe

	assign req_rise = stb_req_i & ~req_q;

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			req_q       <= 1'b0;
			int_stb_q   <= 1'b0;
			rdy_o       <= 1'b0;
			stb_valid_o <= 1'b0;
		end else begin
			req_q <= stb_req_i;

			if (zero_hold_evt_i)
				int_stb_q <= 1'b0;
			else if (stb_end_evt_i)
				int_stb_q <= 1'b1;  // rising edge of the generated strobe

			if (stb_end_evt_i) rdy_o <= 1'b1;  // first strobe is out

			// request opens a window, the next rising edge closes it
			if (req_rise && rdy_o)
				stb_valid_o <= 1'b0;
			else if (stb_end_evt_i)
				stb_valid_o <= 1'b1;
		end
	end

	// idle state forces the line high
	assign stb_o = stb_valid_o | int_stb_q;

	// once running, a zero-hold always cuts a strobe that is high
	a_zero_hold_on_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
		(zero_hold_evt_i && rdy_o) |-> int_stb_q)
		else $error("zero-hold event while the generated strobe is low");

endmodule

/* stb_gen_top.sv */
// strobe generator top
// measures the period of sig_i once after reset, then runs a strobe locked
// to that period; counter, decode, scheduling and output stages

`include "stb_macros.svh"

module stb_gen_top (
	input  logic             clk_i,
	input  logic             arstn_i,
	input  logic             sig_i,
	input  logic             stb_req_i,
	output logic             err_o,
	output logic             rdy_o,
	output logic             stb_o,
	output logic             stb_valid_o,
	output stb_pkg::tstamp_t stb_period_o
);
	stb_pkg::tstamp_t     t_cnt;
	stb_pkg::meas_state_e state;
	logic                 gen_start_evt;
	logic                 stb_end_evt;
	logic                 zero_hold_evt;

	stb_time_counter u_time_counter (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.t_cnt_o (t_cnt)
	);

	// decode
	stb_period_meas u_period_meas (
		.clk_i           (clk_i),
		.arstn_i         (arstn_i),
		.sig_i           (sig_i),
		.t_cnt_i         (t_cnt),
		.gen_start_evt_i (gen_start_evt),
		.stb_end_evt_i   (stb_end_evt),
		.state_o         (state),
		.period_o        (stb_period_o),
		.period_valid_o  (),
		.err_o           (err_o)
	);

	// execute
	stb_event_sched u_event_sched (
		.clk_i           (clk_i),
		.arstn_i         (arstn_i),
		.t_cnt_i         (t_cnt),
		.state_i         (state),
		.period_i        (stb_period_o),
		.gen_start_evt_o (gen_start_evt),
		.stb_end_evt_o   (stb_end_evt),
		.zero_hold_evt_o (zero_hold_evt)
	);

	// result
	stb_output u_output (
		.clk_i           (clk_i),
		.arstn_i         (arstn_i),
		.stb_req_i       (stb_req_i),
		.stb_end_evt_i   (stb_end_evt),
		.zero_hold_evt_i (zero_hold_evt),
		.stb_o           (stb_o),
		.rdy_o           (rdy_o),
		.stb_valid_o     (stb_valid_o)
	);

endmodule

/* tb_stb_gen.sv */
// strobe generator testbench
// random sig_i periods plus one period below the minimum, request windows
// timed onto the strobe edges, checks done by concurrent assertions

`include "stb_macros.svh"

module tb_stb_gen;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS  = 4;
	localparam int WD_PERIODS = 20;    // run budget per test, in sig_i periods
	localparam int WD_MARGIN  = 1000;

	logic             clk_i     = 1'b0;
	logic             arstn_i   = 1'b1;  // pulled low at time zero by the first test
	logic             sig_i     = 1'b0;
	logic             stb_req_i = 1'b0;
	logic             err_o;
	logic             rdy_o;
	logic             stb_o;
	logic             stb_valid_o;
	stb_pkg::tstamp_t stb_period_o;

	int          periods [NUM_TESTS];
	int          exp_period = 1;
	logic        exp_err    = 1'b0;
	logic        sig_run    = 1'b0;
	int          sig_phase  = 0;
	int          sig_edges  = 0;    // rising edges driven since reset
	logic [31:0] rng        = 32'hc482_d077;
	int          wd_cycles  = WD_MARGIN;
	logic        wd_armed   = 1'b0;
	logic        failed     = 1'b0;

	// monitor state, one sample per rising clock edge
	logic stb_prev;
	logic valid_prev;
	logic req_prev;
	logic has_rise;
	logic low_run;     // stb_valid_o low on every sample since the last rise
	logic full_low;    // low phase started by the generated strobe
	int   rise_gap;
	int   low_cnt;
	int   vlow_cnt;    // samples with stb_valid_o low since the last request

	stb_gen_top stb_gen_top_i (
		.clk_i        (clk_i),
		.arstn_i      (arstn_i),
		.sig_i        (sig_i),
		.stb_req_i    (stb_req_i),
		.err_o        (err_o),
		.rdy_o        (rdy_o),
		.stb_o        (stb_o),
		.stb_valid_o  (stb_valid_o),
		.stb_period_o (stb_period_o)
	);

	always #4 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string msg);
		failed = 1'b1;
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	always @(negedge clk_i) begin
		if (!sig_run) begin
			sig_i     = 1'b0;
			sig_phase = 0;
			sig_edges = 0;
		end else begin
			if (sig_phase == 0)
				sig_edges = sig_edges + 1;
			sig_i     = (sig_phase < exp_period / 2);  // square wave, high first
			sig_phase = (sig_phase + 1) % exp_period;
		end
	end

	task automatic pulse_request();
		stb_req_i = 1'b1;
		@(negedge clk_i);
		stb_req_i = 1'b0;
	endtask

	task automatic wait_for_rdy(input int p);
		int n;
		n = 0;
		while (!rdy_o && n < 8 * p + 50) begin
			@(negedge clk_i);
			n++;
		end
		if (!rdy_o)
			report_failure("rdy_o did not rise after the third edge of sig_i");
	endtask

	task automatic wait_for_err(input int p);
		int n;
		n = 0;
		while (!err_o && n < 8 * p + 50) begin
			@(negedge clk_i);
			n++;
		end
		if (!err_o)
			report_failure("err_o did not rise for a period below the minimum");
	endtask

	task automatic exercise_requests(input int p);
		logic prev;
		logic found;
		int   n;
		rng = xorshift32(rng);
		repeat (1 + int'(rng % p)) @(negedge clk_i);
		pulse_request();                        // opens a window at a random point
		found = 1'b0;
		prev  = stb_o;
		for (n = 0; n < 2 * p + 10 && !found; n++) begin
			@(negedge clk_i);
			found = stb_o && !prev;
			prev  = stb_o;
		end
		if (!found) begin
			report_failure("no rising edge of stb_o after a request");
		end else begin
			// each pulse now lands on an end event and re-arms the window
			repeat (p - 1) @(negedge clk_i);
			repeat (3) begin
				pulse_request();
				repeat (p - 1) @(negedge clk_i);
			end
		end
	endtask

	task automatic run_test(input int p);
		exp_period = p;
		exp_err    = (p < `STB_MIN_PERIOD);
		sig_run    = 1'b0;
		stb_req_i  = 1'b0;
		arstn_i    = 1'b0;
		repeat (5) @(negedge clk_i);
		arstn_i = 1'b1;
		@(posedge clk_i);
		sig_run = 1'b1;
		if (exp_err) begin
			wait_for_err(p);
			repeat (4 * p) @(negedge clk_i);
		end else begin
			wait_for_rdy(p);
			exercise_requests(p);
			repeat (2 * p) @(negedge clk_i);
		end
	endtask

	initial begin
		int k;
		for (k = 0; k < NUM_TESTS - 1; k++) begin
			rng        = xorshift32(rng);
			periods[k] = 40 + int'(rng % 161);
		end
		periods[NUM_TESTS-1] = 10;              // below the minimum period
		for (k = 0; k < NUM_TESTS; k++)
			wd_cycles += WD_PERIODS * periods[k];
		wd_armed = 1'b1;
		for (k = 0; k < NUM_TESTS; k++)
			run_test(periods[k]);
		if (!failed)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		wait (wd_armed);
		repeat (wd_cycles) @(posedge clk_i);
		report_failure($sformatf("timeout, run not finished after %0d cycles", wd_cycles));
	end

	// ----------------------------------------
	// monitor and checks
	// ----------------------------------------
	always @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			stb_prev   <= 1'b0;
			valid_prev <= 1'b0;
			req_prev   <= 1'b0;
			has_rise   <= 1'b0;
			low_run    <= 1'b0;
			full_low   <= 1'b0;
			rise_gap   <= 0;
			low_cnt    <= 0;
			vlow_cnt   <= 0;
		end else begin
			stb_prev   <= stb_o;
			valid_prev <= stb_valid_o;
			req_prev   <= stb_req_i;
			if (stb_o && !stb_prev) begin
				has_rise <= 1'b1;
				rise_gap <= 1;
				low_run  <= !stb_valid_o;
			end else begin
				rise_gap <= rise_gap + 1;
				low_run  <= low_run && !stb_valid_o;
			end
			if (!stb_o && stb_prev) begin
				low_cnt  <= 1;
				full_low <= !valid_prev;        // not a window opening
			end else if (!stb_o) begin
				low_cnt <= low_cnt + 1;
			end
			if (stb_req_i && !req_prev && rdy_o)
				vlow_cnt <= 0;
			else if (!stb_valid_o && rdy_o)
				vlow_cnt <= vlow_cnt + 1;
		end
	end

	reset_outputs_low: assert property (@(posedge clk_i)
		(!arstn_i || $rose(arstn_i)) |-> !(err_o || rdy_o || stb_o || stb_valid_o))
		else report_failure($sformatf(
			"CHECK FAILED: reset err_o=0x%0h rdy_o=0x%0h stb_o=0x%0h stb_valid_o=0x%0h",
			err_o, rdy_o, stb_o, stb_valid_o));

	period_matches: assert property (@(posedge clk_i) disable iff (!arstn_i)
		rdy_o |-> stb_period_o == stb_pkg::tstamp_t'(exp_period))
		else report_failure($sformatf("CHECK FAILED: stb_period_o = 0x%0h, expected 0x%0h",
			stb_period_o, exp_period));

	strobe_rise_spacing: assert property (@(posedge clk_i) disable iff (!arstn_i)
		(stb_o && !stb_prev && has_rise && low_run) |-> rise_gap == exp_period)
		else report_failure($sformatf("CHECK FAILED: stb_o rise gap = 0x%0h, expected 0x%0h",
			rise_gap, exp_period));

	zero_hold_length: assert property (@(posedge clk_i) disable iff (!arstn_i)
		(stb_o && !stb_prev && full_low) |-> low_cnt == `STB_ZERO_HOLD)
		else report_failure($sformatf("CHECK FAILED: stb_o low cycles = 0x%0h, expected 0x%0h",
			low_cnt, `STB_ZERO_HOLD));

	request_drops_valid: assert property (@(posedge clk_i) disable iff (!arstn_i)
		(stb_req_i && !req_prev && rdy_o) |=> !stb_valid_o)
		else report_failure("CHECK FAILED: stb_valid_o = 0x1 after a request, expected 0x0");

	valid_returns: assert property (@(posedge clk_i) disable iff (!arstn_i)
		rdy_o |-> vlow_cnt <= exp_period)
		else report_failure("stb_valid_o stayed low longer than one period after a request");

	idle_keeps_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
		stb_valid_o |-> stb_o)
		else report_failure("CHECK FAILED: stb_o = 0x0 while stb_valid_o = 0x1, expected 0x1");

	err_only_short: assert property (@(posedge clk_i) disable iff (!arstn_i)
		err_o |-> exp_err)
		else report_failure("CHECK FAILED: err_o = 0x1, expected 0x0");

	err_after_edges: assert property (@(posedge clk_i) disable iff (!arstn_i)
		err_o |-> sig_edges >= 3)
		else report_failure("err_o rose before the third rising edge of sig_i");

	err_blocks_rdy: assert property (@(posedge clk_i) disable iff (!arstn_i)
		exp_err |-> !rdy_o)
		else report_failure("CHECK FAILED: rdy_o = 0x1 with a short period, expected 0x0");

endmodule

/* compile.f */
+incdir+.
stb_pkg.sv
stb_time_counter.sv
pipelined_adder.sv
pipelined_equal.sv
stb_period_meas.sv
stb_event_sched.sv
stb_output.sv
stb_gen_top.sv
tb_stb_gen.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP        = tb_stb_gen
FILELIST   = compile.f
LOG        = sim.log
FAIL_MSG   = Test failures found
PASS_MSG   = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir $(LOG)
